/* common/mmio_consts.svh */
// Widths, FIFO depth, read timeout and response codes for the host MMIO channel
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// Host address and data widths
`define MMIO_ADDR_W 20
`define MMIO_DATA_W 64

// Entries in each of the request and response FIFOs
`define MMIO_FIFO_DEPTH 4

// Cycles a read may wait for the AFU before the channel drops into fault mode
`define MMIO_RD_TIMEOUT 64
`define MMIO_TIMER_W 8

// Read data returned to the host once the AFU has been declared dead
`define MMIO_FAULT_DATA {`MMIO_DATA_W{1'b1}}

// AXI response codes
`define MMIO_RESP_OKAY 2'b00
`define MMIO_RESP_SLVERR 2'b10

`endif

/* common/mmio_pkg.sv */
// Shared types for the host MMIO channel: request words, write beats, tracker states
`include "mmio_consts.svh"

package mmio_pkg;

    // One MMIO request word as seen by the AFU
    // Reads are always full width and aligned
    // A 4 byte write always has its data in payload bits 31:0
    typedef struct packed {
        logic                    is_write;
        logic [`MMIO_ADDR_W-1:0] addr;
        // Number of valid bytes, either 4 or 8
        logic [3:0]              byte_count;
        logic [`MMIO_DATA_W-1:0] payload;
    } mmio_afu_req_t;

    // Host write data beat, carried through the W skid buffer
    typedef struct packed {
        logic [`MMIO_DATA_W-1:0]   data;
        logic [`MMIO_DATA_W/8-1:0] strb;
    } mmio_wbeat_t;

    // States of the outstanding read tracker
    // IDLE allows a new read to be granted
    // WAIT_RSP holds off further reads until the AFU answers or the timer fires
    // FAULT is sticky and answers reads locally with an error response
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WAIT_RSP = 2'd1,
        FAULT    = 2'd2
    } mmio_rd_state_t;

endpackage

/* src/axi_lite_skid.sv */
// Two-entry skid buffer with a registered ready, used on the host AW, W and AR channels
module axi_lite_skid
    import mmio_pkg::*;
#(
    parameter type payload_t = mmio_wbeat_t
)
(
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    payload_t skid_data;
    logic     push;
    logic     out_free;
    logic     out_valid_nxt;
    logic     skid_valid_nxt;

    assign push = in_valid && in_ready;

    // The output register can take new data when it is empty or being drained
    assign out_free = !out_valid || out_ready;

    always_comb
    begin
        if (out_free)
        begin
            // Skid entry drains first, otherwise the incoming beat goes straight out
            out_valid_nxt = skid_valid || push;
            skid_valid_nxt = 1'b0;
        end
        else
        begin
            // Output is stalled so an incoming beat parks in the skid entry
            out_valid_nxt = 1'b1;
            skid_valid_nxt = skid_valid || push;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready <= 1'b0;
        end
        else
        begin
            out_valid <= out_valid_nxt;
            skid_valid <= skid_valid_nxt;
            // Ready only looks at buffer occupancy, never at in_valid
            in_ready <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            if (skid_valid)
                out_data <= skid_data;
            else if (push)
                out_data <= in_data;
        end
        else if (push)
        begin
            skid_data <= in_data;
        end
    end

endmodule

/* src/mmio_fifo.sv */
// Synchronous valid/ready FIFO for the MMIO request and response paths
`include "mmio_consts.svh"

module mmio_fifo
    import mmio_pkg::*;
#(
    parameter type payload_t = mmio_afu_req_t
)
(
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int DEPTH = `MMIO_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             push;
    logic             pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // Push and pop in the same cycle leave the count unchanged
    always_comb
    begin
        count_nxt = count;
        if (push && !pop)
            count_nxt = count + 1'b1;
        else if (pop && !push)
            count_nxt = count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_ready <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_nxt;
            // Both flags are registered from the next count
            in_ready <= (count_nxt != CNT_W'(DEPTH));
            out_valid <= (count_nxt != '0);
        end
    end

    // Storage has no reset, only the pointers and count qualify it
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    assign out_data = mem[rd_ptr];

endmodule

/* mmio_bridge/mmio_axi_lite_bridge.sv */
// Arbitrates host reads and writes into MMIO request words and returns B and R data
`include "mmio_consts.svh"

module mmio_axi_lite_bridge
    import mmio_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    // Skid buffer outputs for the host request channels
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  logic [`MMIO_ADDR_W-1:0] aw_addr,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  mmio_wbeat_t             w_beat,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  logic [`MMIO_ADDR_W-1:0] ar_addr,

    // Host write response
    input  logic                    bready,
    output logic                    bvalid,
    output logic [1:0]              bresp,

    // Request FIFO push side
    output logic                    req_valid,
    input  logic                    req_ready,
    output mmio_afu_req_t           req,

    // Read tracker
    input  logic                    rd_allow,
    output logic                    rd_grant,
    input  logic                    r_fault,

    // Read response data
    input  logic [`MMIO_DATA_W-1:0] rsp_data,
    output logic [`MMIO_DATA_W-1:0] rdata,
    output logic [1:0]              rresp
);

    logic pend_wr;
    logic pend_rd;
    logic grant_wr;
    logic grant_rd;
    // Set when the last grant went to the write client
    logic last_wr;

    // A write needs address and data together, and B must be free since
    // the write is committed to the host in the same cycle it is granted
    assign pend_wr = aw_valid && w_valid && bready;

    // The tracker holds reads back while one is still outstanding
    assign pend_rd = ar_valid && rd_allow;

    // Two-client round robin, the client not served last wins a tie
    assign grant_wr = req_ready && pend_wr && (!pend_rd || !last_wr);
    assign grant_rd = req_ready && pend_rd && (!pend_wr || last_wr);

    always_ff @(posedge clk)
    begin
        if (rst)
            last_wr <= 1'b0;
        else if (grant_wr)
            last_wr <= 1'b1;
        else if (grant_rd)
            last_wr <= 1'b0;
    end

    assign aw_ready = grant_wr;
    assign w_ready = grant_wr;
    assign ar_ready = grant_rd;
    assign rd_grant = grant_rd;

    assign bvalid = grant_wr;
    assign bresp = `MMIO_RESP_OKAY;

    // In fault mode reads are answered locally, so the AFU never sees them
    assign req_valid = grant_wr || (grant_rd && !r_fault);

    always_comb
    begin
        req = '0;
        req.is_write = grant_wr;

        if (grant_rd)
        begin
            // Reads are always a full aligned qword
            req.addr = ar_addr;
            req.byte_count = 4'd8;
        end
        else
        begin
            req.addr = aw_addr;
            req.byte_count = (w_beat.strb[0] && w_beat.strb[4]) ? 4'd8 : 4'd4;
            req.payload = w_beat.data;
            // An upper-word write arrives in data bits 63:32 and the AFU
            // expects it to start at payload bit 0
            if (!w_beat.strb[0])
                req.payload[31:0] = w_beat.data[63:32];
        end
    end

    // Read data path, the tracker decides when rvalid is raised
    assign rdata = r_fault ? `MMIO_FAULT_DATA : rsp_data;
    assign rresp = r_fault ? `MMIO_RESP_SLVERR : `MMIO_RESP_OKAY;

endmodule

/* mmio_bridge/mmio_rd_track_fsm.sv */
// Tracks the single outstanding read, its timeout and the sticky fault mode
module mmio_rd_track_fsm
    import mmio_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // Bridge side
    input  logic rd_grant,
    output logic rd_allow,
    output logic r_fault,

    // Response FIFO
    input  logic rsp_valid,
    output logic rsp_pop,

    // Host R channel handshake
    input  logic rready,
    output logic rvalid,

    // Timeout timer
    output logic timer_start,
    output logic timer_running,
    input  logic timer_expired,

    output logic error
);

    mmio_rd_state_t state;
    mmio_rd_state_t state_nxt;
    // A locally generated fault response is waiting for rready
    logic           fault_pend;

    always_comb
    begin
        state_nxt = state;
        rd_allow = 1'b0;
        rvalid = 1'b0;
        rsp_pop = 1'b0;
        timer_start = 1'b0;

        case (state)
            IDLE:
            begin
                rd_allow = 1'b1;
                if (rd_grant)
                begin
                    state_nxt = WAIT_RSP;
                    timer_start = 1'b1;
                end
            end
            WAIT_RSP:
            begin
                // The response FIFO output goes straight to the host
                rvalid = rsp_valid;
                rsp_pop = rsp_valid && rready;
                if (rsp_pop)
                    state_nxt = IDLE;
                // A response already waiting on the host wins over the timer
                else if (timer_expired && !rsp_valid)
                    state_nxt = FAULT;
            end
            FAULT:
            begin
                // Late or stray AFU responses are discarded
                rsp_pop = rsp_valid;
                rvalid = fault_pend;
                rd_allow = !fault_pend;
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            fault_pend <= 1'b0;
            error <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == WAIT_RSP && state_nxt == FAULT)
            begin
                // The timed out read itself gets the first fault response
                fault_pend <= 1'b1;
                error <= 1'b1;
            end
            else if (state == FAULT)
            begin
                if (rd_grant)
                    fault_pend <= 1'b1;
                else if (fault_pend && rready)
                    fault_pend <= 1'b0;
            end
        end
    end

    assign r_fault = (state == FAULT);
    assign timer_running = (state == WAIT_RSP);

endmodule

/* mmio_bridge/mmio_timeout_timer.sv */
// Counts cycles of an outstanding read and flags when the response is overdue
`include "mmio_consts.svh"

module mmio_timeout_timer
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic running,
    output logic expired
);

    logic [`MMIO_TIMER_W-1:0] count;
    logic [`MMIO_TIMER_W-1:0] count_nxt;

    // Restart from zero on a new read, otherwise count up and stick at the top
    always_comb
    begin
        count_nxt = count;
        if (start)
            count_nxt = '0;
        else if (running && count != '1)
            count_nxt = count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
            expired <= 1'b0;
        end
        else
        begin
            count <= count_nxt;
            expired <= (count_nxt >= `MMIO_TIMER_W'(`MMIO_RD_TIMEOUT));
        end
    end

endmodule

/* src/mmio_host_chan_top.sv */
// Host MMIO channel top that joins the AXI-Lite skids, bridge, read tracker and FIFOs
`include "mmio_consts.svh"

module mmio_host_chan_top
    import mmio_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // Host AXI-Lite
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`MMIO_ADDR_W-1:0]   awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [`MMIO_DATA_W-1:0]   wdata,
    input  logic [`MMIO_DATA_W/8-1:0] wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`MMIO_ADDR_W-1:0]   araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`MMIO_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,

    // MMIO requests to the AFU
    output logic                      afu_req_valid,
    input  logic                      afu_req_ready,
    output logic                      afu_req_is_write,
    output logic [`MMIO_ADDR_W-1:0]   afu_req_addr,
    output logic [3:0]                afu_req_byte_count,
    output logic [`MMIO_DATA_W-1:0]   afu_req_payload,

    // AFU read responses
    input  logic                      afu_rsp_valid,
    output logic                      afu_rsp_ready,
    input  logic [`MMIO_DATA_W-1:0]   afu_rsp_data,

    output logic                      error
);

    // Skid outputs into the bridge
    logic                    aw_valid;
    logic                    aw_ready;
    logic [`MMIO_ADDR_W-1:0] aw_addr;
    logic                    w_valid;
    logic                    w_ready;
    mmio_wbeat_t             w_beat;
    logic                    ar_valid;
    logic                    ar_ready;
    logic [`MMIO_ADDR_W-1:0] ar_addr;

    // Bridge to request FIFO
    logic                    req_valid;
    logic                    req_ready;
    mmio_afu_req_t           req;
    mmio_afu_req_t           afu_req;

    // Response FIFO, tracker and timer
    logic                    rsp_valid;
    logic                    rsp_pop;
    logic [`MMIO_DATA_W-1:0] rsp_data;
    logic                    rd_allow;
    logic                    rd_grant;
    logic                    r_fault;
    logic                    timer_start;
    logic                    timer_running;
    logic                    timer_expired;

    axi_lite_skid #(.payload_t(logic [`MMIO_ADDR_W-1:0])) aw_skid
    (
        .clk(clk), .rst(rst),
        .in_valid(awvalid), .in_ready(awready), .in_data(awaddr),
        .out_valid(aw_valid), .out_ready(aw_ready), .out_data(aw_addr)
    );

    // Data and strobe are packed into one write beat
    axi_lite_skid #(.payload_t(mmio_wbeat_t)) w_skid
    (
        .clk(clk), .rst(rst),
        .in_valid(wvalid), .in_ready(wready), .in_data({wdata, wstrb}),
        .out_valid(w_valid), .out_ready(w_ready), .out_data(w_beat)
    );

    axi_lite_skid #(.payload_t(logic [`MMIO_ADDR_W-1:0])) ar_skid
    (
        .clk(clk), .rst(rst),
        .in_valid(arvalid), .in_ready(arready), .in_data(araddr),
        .out_valid(ar_valid), .out_ready(ar_ready), .out_data(ar_addr)
    );

    mmio_axi_lite_bridge bridge
    (
        .clk(clk), .rst(rst),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_beat(w_beat),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .bready(bready), .bvalid(bvalid), .bresp(bresp),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rd_allow(rd_allow), .rd_grant(rd_grant), .r_fault(r_fault),
        .rsp_data(rsp_data), .rdata(rdata), .rresp(rresp)
    );

    mmio_fifo #(.payload_t(mmio_afu_req_t)) req_fifo
    (
        .clk(clk), .rst(rst),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(afu_req_valid), .out_ready(afu_req_ready), .out_data(afu_req)
    );

    assign afu_req_is_write = afu_req.is_write;
    assign afu_req_addr = afu_req.addr;
    assign afu_req_byte_count = afu_req.byte_count;
    assign afu_req_payload = afu_req.payload;

    mmio_fifo #(.payload_t(logic [`MMIO_DATA_W-1:0])) rsp_fifo
    (
        .clk(clk), .rst(rst),
        .in_valid(afu_rsp_valid), .in_ready(afu_rsp_ready), .in_data(afu_rsp_data),
        .out_valid(rsp_valid), .out_ready(rsp_pop), .out_data(rsp_data)
    );

    mmio_rd_track_fsm rd_track
    (
        .clk(clk), .rst(rst),
        .rd_grant(rd_grant), .rd_allow(rd_allow), .r_fault(r_fault),
        .rsp_valid(rsp_valid), .rsp_pop(rsp_pop),
        .rready(rready), .rvalid(rvalid),
        .timer_start(timer_start), .timer_running(timer_running),
        .timer_expired(timer_expired),
        .error(error)
    );

    mmio_timeout_timer rd_timer
    (
        .clk(clk), .rst(rst),
        .start(timer_start), .running(timer_running), .expired(timer_expired)
    );

endmodule

/* sim/tb_mmio_host_chan.sv */
// Testbench for the host MMIO channel with an AFU model, a host driver and a scoreboard
`include "mmio_consts.svh"

module tb_mmio_host_chan
    import mmio_pkg::*;
;

    // Random transactions, plus the scripted, timeout and fault mode ones
    localparam int N_RAND = 40;
    localparam int N_TXN = N_RAND + 16;
    localparam longint WATCHDOG_T = N_TXN * (`MMIO_RD_TIMEOUT + 40) * 20;

    logic clk, rst, awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready;
    logic rvalid, rready, afu_req_valid, afu_req_ready, afu_req_is_write;
    logic afu_rsp_valid, afu_rsp_ready, error;
    logic [`MMIO_ADDR_W-1:0] awaddr, araddr, afu_req_addr;
    logic [63:0] wdata, rdata, afu_req_payload, afu_rsp_data;
    logic [7:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [3:0] afu_req_byte_count;

    mmio_afu_req_t exp_req_q[$];
    logic [63:0] exp_rdata_q[$];
    logic [1:0] exp_rresp_q[$];
    logic [63:0] shadow [16];
    logic [63:0] afu_regs [16];
    int errors = 0;
    int wr_issued = 0;
    int rd_issued = 0;
    int b_count = 0;
    int r_count = 0;
    // AFU model state
    // While mute is set the model holds back its read responses
    logic mute = 1'b0;
    logic rd_outstanding = 1'b0;
    logic rsp_timer_run = 1'b0;
    int rsp_delay = 0;
    logic [63:0] rsp_hold;

    mmio_host_chan_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp)
        else
        begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // R data is held while rready is low, and error never falls once raised
    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else
    begin
        errors++;
        $display("R channel changed while rready was low");
    end
    assert property (@(posedge clk) disable iff (rst) error |=> error)
    else
    begin
        errors++;
        $display("error dropped after it was raised");
    end

    // Random back-pressure from the host and the AFU
    always @(posedge clk)
    begin
        if (!rst)
        begin
            bready <= ($urandom % 4) != 0;
            rready <= ($urandom % 3) != 0;
            afu_req_ready <= ($urandom % 3) != 0;
        end
    end

    // AFU model and request scoreboard
    always @(posedge clk)
    begin
        mmio_afu_req_t exp;
        if (!rst)
        begin
            if (afu_rsp_valid && afu_rsp_ready)
            begin
                afu_rsp_valid <= 1'b0;
                rd_outstanding = 1'b0;
            end
            if (rsp_timer_run)
            begin
                if (rsp_delay == 0)
                begin
                    afu_rsp_valid <= 1'b1;
                    afu_rsp_data <= rsp_hold;
                    rsp_timer_run = 1'b0;
                end
                else
                    rsp_delay--;
            end
            if (afu_req_valid && afu_req_ready)
            begin
                if (exp_req_q.size() == 0)
                begin
                    errors++;
                    $display("AFU received a request that no host transaction asked for");
                end
                else
                begin
                    exp = exp_req_q.pop_front();
                    check_value("afu_req_is_write", 64'(afu_req_is_write), 64'(exp.is_write));
                    check_value("afu_req_addr", 64'(afu_req_addr), 64'(exp.addr));
                    check_value("afu_req_byte_count", 64'(afu_req_byte_count),
                        64'(exp.byte_count));
                    if (exp.is_write && exp.byte_count == 4'd8)
                        check_value("afu_req_payload", afu_req_payload, exp.payload);
                    else if (exp.is_write)
                        check_value("afu_req_payload[31:0]", 64'(afu_req_payload[31:0]),
                            64'(exp.payload[31:0]));
                end
                if (afu_req_is_write && afu_req_byte_count == 4'd8)
                    afu_regs[afu_req_addr[6:3]] = afu_req_payload;
                else if (afu_req_is_write && afu_req_addr[2])
                    afu_regs[afu_req_addr[6:3]][63:32] = afu_req_payload[31:0];
                else if (afu_req_is_write)
                    afu_regs[afu_req_addr[6:3]][31:0] = afu_req_payload[31:0];
                else
                begin
                    assert (!rd_outstanding)
                    else
                    begin
                        errors++;
                        $display("AFU got a second read while one was unanswered");
                    end
                    rd_outstanding = 1'b1;
                    rsp_hold = afu_regs[afu_req_addr[6:3]];
                    rsp_delay = $urandom % 11;
                    rsp_timer_run = !mute;
                end
            end
        end
    end

    // Host B and R monitors
    always @(posedge clk)
    begin
        if (!rst && bvalid && bready)
        begin
            check_value("bresp", 64'(bresp), 64'(`MMIO_RESP_OKAY));
            b_count++;
            if (b_count > wr_issued)
            begin
                errors++;
                $display("B response arrived with no write waiting for it");
            end
        end
        if (!rst && rvalid && rready)
        begin
            if (exp_rdata_q.size() == 0)
            begin
                errors++;
                $display("R response arrived with no read waiting for it");
            end
            else
            begin
                check_value("rdata", rdata, exp_rdata_q.pop_front());
                check_value("rresp", 64'(rresp), 64'(exp_rresp_q.pop_front()));
            end
            r_count++;
        end
    end

    task automatic host_write(input logic [19:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
        mmio_afu_req_t exp;
        logic aw_done;
        logic w_done;
        exp = '0;
        exp.is_write = 1'b1;
        exp.addr = addr;
        exp.byte_count = (strb == 8'hFF) ? 4'd8 : 4'd4;
        exp.payload = strb[0] ? data : {32'h0, data[63:32]};
        exp_req_q.push_back(exp);
        if (strb == 8'hFF)
            shadow[addr[6:3]] = data;
        else if (strb[0])
            shadow[addr[6:3]][31:0] = data[31:0];
        else
            shadow[addr[6:3]][63:32] = data[63:32];
        wr_issued++;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done))
        begin
            @(posedge clk);
            if (!aw_done && awvalid && awready)
            begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (!w_done && wvalid && wready)
            begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        wait (b_count >= wr_issued);
    endtask

    // Drives one AR beat and queues what the AFU and the host should see for it
    // A read made in fault mode never reaches the AFU
    // A timed out or faulted read comes back as all ones with SLVERR
    task automatic send_read(input logic [19:0] addr, input logic to_afu, input logic fault);
        mmio_afu_req_t exp;
        exp = '0;
        exp.addr = addr;
        exp.byte_count = 4'd8;
        if (to_afu)
            exp_req_q.push_back(exp);
        exp_rdata_q.push_back(fault ? 64'hFFFF_FFFF_FFFF_FFFF : shadow[addr[6:3]]);
        exp_rresp_q.push_back(fault ? `MMIO_RESP_SLVERR : `MMIO_RESP_OKAY);
        rd_issued++;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        do
            @(posedge clk);
        while (!(arvalid && arready));
        arvalid <= 1'b0;
    endtask

    task automatic host_read(input logic [19:0] addr, input logic to_afu, input logic fault);
        send_read(addr, to_afu, fault);
        wait (r_count >= rd_issued);
    endtask

    initial
    begin
        #(WATCHDOG_T);
        $display("Run stopped by the watchdog, a handshake never completed");
        $display("Errors: %0d", errors + 1);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [19:0] addr;
        void'($urandom(19813));
        for (int i = 0; i < 16; i++)
        begin
            shadow[i] = '0;
            afu_regs[i] = '0;
        end
        {awvalid, wvalid, arvalid, afu_rsp_valid} = '0;
        {bready, rready, afu_req_ready} = 3'b111;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = '0;
        afu_rsp_data = '0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        host_write(20'h12018, 64'h0123_4567_89AB_CDEF, 8'hFF);
        host_read(20'h12018, 1'b1, 1'b0);
        host_write(20'h12020, 64'hDEAD_0000_1111_2222, 8'h0F);
        host_write(20'h12024, 64'h3333_4444_BEEF_0000, 8'hF0);
        host_read(20'h12020, 1'b1, 1'b0);
        // Two reads issued back to back so the second waits in the AR skid until
        // the first one has been answered
        send_read(20'h12018, 1'b1, 1'b0);
        send_read(20'h12024, 1'b1, 1'b0);
        wait (r_count >= rd_issued);
        for (int i = 0; i < N_RAND; i++)
        begin
            r = $urandom;
            addr = {8'h12, 5'h0, r[3:0], 3'b000};
            case (r[5:4])
                2'd0: host_write(addr, {$urandom, $urandom}, 8'hFF);
                2'd1: host_write(addr, {$urandom, $urandom}, 8'h0F);
                2'd2: host_write(addr | 20'h4, {$urandom, $urandom}, 8'hF0);
                default: host_read(addr, 1'b1, 1'b0);
            endcase
        end
        check_value("error", 64'(error), 64'h0);
        // The muted AFU lets this read time out, which leaves the channel in fault mode
        mute = 1'b1;
        host_read(20'h12008, 1'b1, 1'b1);
        check_value("error", 64'(error), 64'h1);
        for (int i = 0; i < 4; i++)
        begin
            host_read(20'h12010, 1'b0, 1'b1);
            host_write(20'h12030, {$urandom, $urandom}, 8'hFF);
        end
        while (exp_req_q.size() != 0)
            @(posedge clk);
        repeat (5) @(posedge clk);
        check_value("error", 64'(error), 64'h1);
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/mmio_pkg.sv
src/axi_lite_skid.sv
src/mmio_fifo.sv
mmio_bridge/mmio_axi_lite_bridge.sv
mmio_bridge/mmio_rd_track_fsm.sv
mmio_bridge/mmio_timeout_timer.sv
src/mmio_host_chan_top.sv
sim/tb_mmio_host_chan.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the host MMIO channel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_mmio_host_chan -o sim_bin
out="$(./obj_dir/sim_bin)"
echo "$out"
echo "$out" | grep -q "Test passed"
